// ==== sim.f ====
src/l1_pkg.sv
src/req_router.sv
src/cache_bank.sv
src/mem_arbiter.sv
src/l1_dcache_top.sv
testbench/tb_l1_dcache.sv

// ==== run.sh ====
#!/bin/sh
# build and run the L1 data cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f sim.f --top-module tb_l1_dcache -o sim_l1_dcache

out=$(./obj_dir/sim_l1_dcache) || true
echo "$out"

if echo "$out" | grep -qx "ALL TESTS PASSED"; then
  exit 0
fi
exit 1

// ==== testbench/tb_l1_dcache.sv ====
// testbench for the banked write-through L1 data cache
//   clock, reset and LFSR driven cpu requests with periodic flushes
//   memory responder with random ack delay and fixed return latency
//   reference model for memory words, tag/valid lines and ids in flight

`timescale 1ns/100ps

module tb_l1_dcache;

  localparam int NumBanks    = 4;
  localparam int SetsPerBank = 8;
  localparam int Lines       = NumBanks * SetsPerBank;
  localparam int Words       = 64;             // address window in words
  localparam int NumOps      = 400;
  localparam int FlushEvery  = 100;
  localparam int MaxCycles   = NumOps * 30;

  logic                clk_i, rst_n_i, flush_i;
  logic                req_i, gnt_o, rsp_vld_o;
  l1_pkg::cpu_req_t    req_data_i;
  l1_pkg::cpu_rsp_t    rsp_o;
  logic                mem_req_vld_o, mem_ack_i, mem_rtrn_vld_i;
  l1_pkg::mem_req_t    mem_req_o;
  l1_pkg::mem_rtrn_t   mem_rtrn_i;
  logic [NumBanks-1:0] miss_o;
  logic                busy_o;

  l1_dcache_top #(
    .NumBanks   (NumBanks),
    .SetsPerBank(SetsPerBank)
  ) uut (
    .clk_i, .rst_n_i, .flush_i,
    .req_i, .req_data_i, .gnt_o, .rsp_vld_o, .rsp_o,
    .mem_req_vld_o, .mem_req_o, .mem_ack_i, .mem_rtrn_vld_i, .mem_rtrn_i,
    .miss_o, .busy_o
  );

  ////////////////////////////////////////////////////////////////////////////
  // testbench state
  ////////////////////////////////////////////////////////////////////////////

  logic [15:0]       lfsr_q;
  logic [31:0]       resp_mem  [Words];     // responder memory
  logic [31:0]       model_mem [Words];     // expected memory
  logic              line_vld  [Lines];     // model tag/valid per bank and set
  logic              line_tag  [Lines];     // only addr bit 7 varies in the window
  logic              tid_busy  [16];
  logic              tid_store [16];
  logic [31:0]       tid_data  [16];        // expected rdata per id
  l1_pkg::cpu_req_t  bank_pend [NumBanks];  // request each bank must send to memory
  logic              pend_vld  [NumBanks];
  logic [NumBanks-1:0] exp_miss;            // miss pulses due this cycle
  logic              granted_q;             // request taken at the last rising edge
  logic              s1_vld, s2_vld;        // two-stage return pipe
  l1_pkg::mem_rtrn_t s1_rtrn, s2_rtrn;
  logic              ack_armed;
  int                ack_cnt;
  logic [3:0]        tid_cnt;
  int                errors, checks, cycles, issued, outstanding, next_flush;

  ////////////////////////////////////////////////////////////////////////////
  // random bits and checks
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);  // x^16+x^14+x^13+x^11+1
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);  // one step per bit
      v      = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (exp === act) else begin
      $display("Mismatch %s expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic expect_true(input string what, input logic cond);
    checks++;
    assert (cond === 1'b1) else begin
      $display("Error: %s", what);
      errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // memory responder
  ////////////////////////////////////////////////////////////////////////////

  task automatic accept_mem_req();
    int               w;
    int               b;
    l1_pkg::cpu_req_t p;
    w = int'(mem_req_o.addr[7:2]);
    b = int'(mem_req_o.bank);
    if (b >= NumBanks || !pend_vld[b]) begin
      expect_true("memory request from a bank with nothing to send", 1'b0);
    end else begin
      p           = bank_pend[b];
      pend_vld[b] = 1'b0;  // exactly one memory access per request
      compare("mem_op", 32'(p.we), 32'(mem_req_o.op));
      compare("mem_addr", 32'({p.addr[15:2], 2'b00}), 32'(mem_req_o.addr));
      if (p.we) begin
        compare("mem_data", p.wdata, mem_req_o.data);
        resp_mem[w] = mem_req_o.data;  // store done at its ack
      end else begin
        s1_vld       = 1'b1;
        s1_rtrn.data = resp_mem[w];
        s1_rtrn.bank = mem_req_o.bank;
      end
    end
  endtask

  task automatic serve_memory();
    // return comes 2 cycles after the ack
    mem_rtrn_vld_i = s2_vld;
    mem_rtrn_i     = s2_rtrn;
    s2_vld         = s1_vld;
    s2_rtrn        = s1_rtrn;
    s1_vld         = 1'b0;
    mem_ack_i      = 1'b0;
    if (!mem_req_vld_o) begin
      ack_armed = 1'b0;
    end else begin
      if (!ack_armed) begin
        ack_cnt   = int'(rand_bits(2));  // 0..3 cycles
        ack_armed = 1'b1;
      end
      if (ack_cnt == 0) begin
        ack_armed = 1'b0;
        mem_ack_i = 1'b1;
        accept_mem_req();
      end else begin
        ack_cnt--;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // cpu side and reference model
  ////////////////////////////////////////////////////////////////////////////

  task automatic issue_request();
    logic [31:0] r;
    req_i            = 1'b1;
    req_data_i.we    = (rand_bits(2) == 0);  // about one store in four
    r                = rand_bits(6);
    req_data_i.addr  = 16'(r << 2);
    req_data_i.wdata = rand_bits(32);
    req_data_i.tid   = tid_cnt;
    tid_cnt++;
  endtask

  task automatic record_grant();
    int   w;
    int   b;
    int   line;
    logic hit;
    w    = int'(req_data_i.addr[7:2]);
    b    = w % NumBanks;  // word interleaved
    line = w % Lines;     // bank and set
    hit  = line_vld[line] && (line_tag[line] == req_data_i.addr[7]);
    expect_true("tid reused while still in flight", !tid_busy[req_data_i.tid]);
    tid_busy[req_data_i.tid]  = 1'b1;
    tid_store[req_data_i.tid] = req_data_i.we;
    tid_data[req_data_i.tid]  = req_data_i.we ? 32'h0 : model_mem[w];
    if (req_data_i.we) begin
      model_mem[w] = req_data_i.wdata;  // no allocate on a store miss
    end else if (!hit) begin
      exp_miss[b]    = 1'b1;
      line_vld[line] = 1'b1;  // fill
      line_tag[line] = req_data_i.addr[7];
    end
    bank_pend[b] = req_data_i;
    pend_vld[b]  = 1'b1;
    outstanding++;
    issued++;
  endtask

  task automatic check_response();
    int t;
    t = int'(rsp_o.tid);
    expect_true("response for a tid with no request in flight", tid_busy[t]);
    if (tid_busy[t]) begin
      compare("is_store", 32'(tid_store[t]), 32'(rsp_o.is_store));
      compare("load_data", tid_data[t], rsp_o.rdata);
      tid_busy[t] = 1'b0;
      outstanding--;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // clock and main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;  // 40 ns period
  end

  // grant is combinational, so catch it with the edge that takes it
  always @(posedge clk_i) begin
    granted_q <= req_i & gnt_o;
  end

  initial begin
    logic done;
    logic timed_out;
    rst_n_i    = 1'b0;
    flush_i    = 1'b0;
    req_i      = 1'b0;
    req_data_i = '0;
    mem_ack_i  = 1'b0;
    mem_rtrn_vld_i = 1'b0;
    mem_rtrn_i = '0;
    lfsr_q     = 16'd58146;
    s1_vld     = 1'b0;
    s2_vld     = 1'b0;
    s1_rtrn    = '0;
    s2_rtrn    = '0;
    ack_armed  = 1'b0;
    ack_cnt    = 0;
    tid_cnt    = '0;
    exp_miss   = '0;
    errors     = 0;
    checks     = 0;
    cycles     = 0;
    issued     = 0;
    outstanding = 0;
    next_flush = FlushEvery;
    done       = 1'b0;
    timed_out  = 1'b0;
    for (int i = 0; i < Words; i++) begin
      resp_mem[i]  = 32'hc0de_0000 ^ (32'(i) * 32'h0001_0203);  // whole word index
      model_mem[i] = resp_mem[i];
    end
    for (int i = 0; i < Lines; i++) begin
      line_vld[i] = 1'b0;
      line_tag[i] = 1'b0;
    end
    for (int i = 0; i < 16; i++) begin
      tid_busy[i]  = 1'b0;
      tid_store[i] = 1'b0;
      tid_data[i]  = '0;
    end
    for (int i = 0; i < NumBanks; i++) begin
      pend_vld[i]  = 1'b0;
      bank_pend[i] = '0;
    end

    repeat (5) @(negedge clk_i);
    expect_true("busy_o high after reset", !busy_o);
    expect_true("outputs active after reset",
                !(gnt_o | rsp_vld_o | mem_req_vld_o | (|miss_o)));
    rst_n_i = 1'b1;

    // sample at the falling edge, then drive the next inputs
    while (!done && !timed_out) begin
      @(negedge clk_i);
      cycles++;
      if (granted_q) begin
        record_grant();  // miss pulse of this grant is visible now
        req_i = 1'b0;
      end
      compare("miss_pulse", 32'(exp_miss), 32'(miss_o));
      exp_miss = '0;
      if (rsp_vld_o) check_response();
      flush_i = 1'b0;
      serve_memory();
      if (!req_i) begin
        if (issued == next_flush) begin
          // drain, then flush while the cache is quiet
          if (outstanding == 0) begin
            expect_true("busy_o high with all responses in", !busy_o);
            flush_i = 1'b1;
            for (int i = 0; i < Lines; i++) line_vld[i] = 1'b0;
            next_flush += FlushEvery;
          end
        end else if (issued < NumOps) begin
          if (rand_bits(2) != 0) issue_request();  // idle gaps now and then
        end else if (outstanding == 0) begin
          done = 1'b1;
        end
      end
      if (cycles >= MaxCycles) timed_out = 1'b1;
    end

    if (timed_out) begin
      $display("Error: timeout after %0d cycles, %0d of %0d requests issued, %0d in flight",
               cycles, issued, NumOps, outstanding);
      errors++;
    end else begin
      @(negedge clk_i);
      expect_true("busy_o high at the end of the run", !busy_o);
      for (int i = 0; i < Words; i++) begin
        compare("mem_array", model_mem[i], resp_mem[i]);
      end
    end

    $display("requests %0d, checks %0d, errors %0d", issued, checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== src/l1_dcache_top.sv ====
// top level of the banked write-through L1 data cache
//   cpu request router
//   NumBanks direct-mapped banks in a generate loop
//   round-robin memory arbiter onto the single memory port

`timescale 1ns/100ps

module l1_dcache_top #(
  parameter int NumBanks    = 4,
  parameter int SetsPerBank = 8
) (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     flush_i,      // one-cycle strobe, only while idle
  // cpu port
  input  logic                     req_i,
  input  l1_pkg::cpu_req_t         req_data_i,
  output logic                     gnt_o,
  output logic                     rsp_vld_o,
  output l1_pkg::cpu_rsp_t         rsp_o,
  // memory port
  output logic                     mem_req_vld_o,
  output l1_pkg::mem_req_t         mem_req_o,
  input  logic                     mem_ack_i,
  input  logic                     mem_rtrn_vld_i,
  input  l1_pkg::mem_rtrn_t        mem_rtrn_i,
  // status
  output logic     [NumBanks-1:0]  miss_o,
  output logic                     busy_o
);

  // router <-> banks
  logic             [NumBanks-1:0] bank_req, bank_gnt, bank_rsp_vld, bank_rsp_take;
  l1_pkg::cpu_req_t                bank_req_data;
  l1_pkg::cpu_rsp_t [NumBanks-1:0] bank_rsp;
  // banks <-> arbiter
  logic             [NumBanks-1:0] mem_vld, mem_ack, rtrn_vld;
  l1_pkg::mem_req_t [NumBanks-1:0] mem_req;
  l1_pkg::mem_rtrn_t               bank_rtrn;
  logic             [NumBanks-1:0] bank_busy;

  assign busy_o = |bank_busy;

  req_router #(
    .NumBanks(NumBanks)
  ) i_router (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .req_i          (req_i),
    .req_data_i     (req_data_i),
    .gnt_o          (gnt_o),
    .rsp_vld_o      (rsp_vld_o),
    .rsp_o          (rsp_o),
    .bank_req_o     (bank_req),
    .bank_req_data_o(bank_req_data),
    .bank_gnt_i     (bank_gnt),
    .bank_rsp_vld_i (bank_rsp_vld),
    .bank_rsp_i     (bank_rsp),
    .bank_rsp_take_o(bank_rsp_take)
  );

  for (genvar b = 0; b < NumBanks; b++) begin : gen_bank
    cache_bank #(
      .NumBanks   (NumBanks),
      .SetsPerBank(SetsPerBank)
    ) i_bank (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .flush_i       (flush_i),
      .req_i         (bank_req[b]),
      .req_data_i    (bank_req_data),
      .gnt_o         (bank_gnt[b]),
      .rsp_vld_o     (bank_rsp_vld[b]),
      .rsp_o         (bank_rsp[b]),
      .rsp_take_i    (bank_rsp_take[b]),
      .mem_req_vld_o (mem_vld[b]),
      .mem_req_o     (mem_req[b]),
      .mem_ack_i     (mem_ack[b]),
      .mem_rtrn_vld_i(rtrn_vld[b]),
      .mem_rtrn_i    (bank_rtrn),
      .miss_o        (miss_o[b]),
      .busy_o        (bank_busy[b])
    );
  end

  mem_arbiter #(
    .NumBanks(NumBanks)
  ) i_arbiter (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .bank_req_vld_i (mem_vld),
    .bank_req_i     (mem_req),
    .bank_ack_o     (mem_ack),
    .bank_rtrn_vld_o(rtrn_vld),
    .bank_rtrn_o    (bank_rtrn),
    .mem_req_vld_o  (mem_req_vld_o),
    .mem_req_o      (mem_req_o),
    .mem_ack_i      (mem_ack_i),
    .mem_rtrn_vld_i (mem_rtrn_vld_i),
    .mem_rtrn_i     (mem_rtrn_i)
  );

endmodule

// ==== src/mem_arbiter.sv ====
// memory port arbiter
//   round-robin pick over the bank request levels, locked until ack
//   stamps the winning bank index into the request
//   steers acks to the winner and returns by their bank tag

`timescale 1ns/100ps

module mem_arbiter #(
  parameter int NumBanks = 4
) (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  // bank side
  input  logic              [NumBanks-1:0]  bank_req_vld_i,
  input  l1_pkg::mem_req_t  [NumBanks-1:0]  bank_req_i,
  output logic              [NumBanks-1:0]  bank_ack_o,
  output logic              [NumBanks-1:0]  bank_rtrn_vld_o,
  output l1_pkg::mem_rtrn_t                 bank_rtrn_o,
  // memory side
  output logic                              mem_req_vld_o,
  output l1_pkg::mem_req_t                  mem_req_o,
  input  logic                              mem_ack_i,
  input  logic                              mem_rtrn_vld_i,
  input  l1_pkg::mem_rtrn_t                 mem_rtrn_i
);

  localparam int BankW   = $clog2(NumBanks);
  localparam int BankIdW = l1_pkg::BANK_ID_W;

  logic [BankW-1:0] rr_ptr_q;   // first bank looked at
  logic             lock_q;     // winner waits for ack
  logic [BankW-1:0] win_q;
  logic [BankW-1:0] pick_idx, win;
  logic             pick_any;

  ////////////////////////////////////////////////////////////////////////////
  // round-robin pick
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    logic [BankW-1:0] cand;
    pick_idx = rr_ptr_q;
    pick_any = 1'b0;
    for (int i = 0; i < NumBanks; i++) begin
      cand = rr_ptr_q + BankW'(i);  // wraps, NumBanks is a power of two
      if (!pick_any && bank_req_vld_i[cand]) begin
        pick_idx = cand;
        pick_any = 1'b1;
      end
    end
  end

  assign win = lock_q ? win_q : pick_idx;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rr_ptr_q <= '0;
      lock_q   <= 1'b0;
      win_q    <= '0;
    end else if (mem_req_vld_o) begin
      if (mem_ack_i) begin
        lock_q   <= 1'b0;
        rr_ptr_q <= win + BankW'(1);  // served bank goes to the back
      end else begin
        lock_q <= 1'b1;
        win_q  <= win;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // forward and steer
  ////////////////////////////////////////////////////////////////////////////

  assign mem_req_vld_o = lock_q | pick_any;

  always_comb begin
    mem_req_o      = bank_req_i[win];
    mem_req_o.bank = BankIdW'(win);
  end

  always_comb begin
    bank_ack_o      = '0;
    bank_ack_o[win] = mem_ack_i & mem_req_vld_o;
  end

  always_comb begin
    for (int i = 0; i < NumBanks; i++) begin
      bank_rtrn_vld_o[i] = mem_rtrn_vld_i & (mem_rtrn_i.bank == BankIdW'(i));
    end
  end

  assign bank_rtrn_o = mem_rtrn_i;  // data broadcast, valid decoded per bank

  // pending request stays put until memory acks it
  a_winner_stable : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (mem_req_vld_o && !mem_ack_i) |=> (mem_req_vld_o && $stable(mem_req_o))
  ) else $error("memory request changed before ack");

endmodule

// ==== src/cache_bank.sv ====
// one direct-mapped write-through cache bank
//   valid/tag/data arrays with one word per line
//   bank FSM for load hit, load miss with fill, and store write-through
//   held response level towards the router, held request level towards memory

`timescale 1ns/100ps

module cache_bank #(
  parameter int NumBanks    = 4,
  parameter int SetsPerBank = 8
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              flush_i,
  // cpu side, from the router
  input  logic              req_i,
  input  l1_pkg::cpu_req_t  req_data_i,
  output logic              gnt_o,
  output logic              rsp_vld_o,
  output l1_pkg::cpu_rsp_t  rsp_o,
  input  logic              rsp_take_i,
  // memory side, towards the arbiter
  output logic              mem_req_vld_o,
  output l1_pkg::mem_req_t  mem_req_o,
  input  logic              mem_ack_i,
  input  logic              mem_rtrn_vld_i,
  input  l1_pkg::mem_rtrn_t mem_rtrn_i,
  // status
  output logic              miss_o,
  output logic              busy_o
);

  localparam int BankW = $clog2(NumBanks);
  localparam int IdxW  = $clog2(SetsPerBank);
  localparam int TagW  = l1_pkg::ADDR_W - 2 - BankW - IdxW;

  l1_pkg::bank_state_e state_q, state_d;

  logic [SetsPerBank-1:0]    valid_q;
  logic [TagW-1:0]           tag_q  [SetsPerBank];
  logic [l1_pkg::DATA_W-1:0] data_q [SetsPerBank];

  l1_pkg::cpu_req_t          req_q;    // request in flight
  logic [l1_pkg::DATA_W-1:0] rdata_q;  // load result or zero for stores
  logic                      miss_q;

  logic [IdxW-1:0] req_idx, fill_idx;
  logic [TagW-1:0] req_tag, fill_tag;
  logic            gnt, hit, fill;

  ////////////////////////////////////////////////////////////////////////////
  // lookup
  ////////////////////////////////////////////////////////////////////////////

  assign req_idx  = req_data_i.addr[2+BankW +: IdxW];   // above the bank bits
  assign req_tag  = req_data_i.addr[l1_pkg::ADDR_W-1 -: TagW];
  assign fill_idx = req_q.addr[2+BankW +: IdxW];
  assign fill_tag = req_q.addr[l1_pkg::ADDR_W-1 -: TagW];

  assign gnt  = req_i & (state_q == l1_pkg::BK_IDLE);
  assign hit  = valid_q[req_idx] & (tag_q[req_idx] == req_tag);
  assign fill = (state_q == l1_pkg::BK_MISS_WAIT) & mem_rtrn_vld_i;

  ////////////////////////////////////////////////////////////////////////////
  // bank FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      l1_pkg::BK_IDLE: begin
        if (gnt) begin
          if (req_data_i.we) state_d = l1_pkg::BK_STORE_REQ;  // write-through always
          else if (hit)      state_d = l1_pkg::BK_RSP;
          else               state_d = l1_pkg::BK_MISS_REQ;
        end
      end
      l1_pkg::BK_MISS_REQ:  if (mem_ack_i)  state_d = l1_pkg::BK_MISS_WAIT;
      l1_pkg::BK_MISS_WAIT: if (fill)       state_d = l1_pkg::BK_RSP;
      l1_pkg::BK_STORE_REQ: if (mem_ack_i)  state_d = l1_pkg::BK_RSP;  // no return for stores
      l1_pkg::BK_RSP:       if (rsp_take_i) state_d = l1_pkg::BK_IDLE;
      default:                              state_d = l1_pkg::BK_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= l1_pkg::BK_IDLE;
      valid_q <= '0;
      miss_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      miss_q  <= gnt & ~req_data_i.we & ~hit;  // one pulse per load miss
      if (fill) valid_q[fill_idx] <= 1'b1;
      // flush wins, only legal while idle anyway
      if (flush_i) valid_q <= '0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // arrays and payload
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (gnt) begin
      req_q   <= req_data_i;
      rdata_q <= req_data_i.we ? '0 : data_q[req_idx];
      // store hit updates the line, store miss does not allocate
      if (req_data_i.we && hit) data_q[req_idx] <= req_data_i.wdata;
    end
    if (fill) begin
      tag_q[fill_idx]  <= fill_tag;
      data_q[fill_idx] <= mem_rtrn_i.data;
      rdata_q          <= mem_rtrn_i.data;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // outputs
  ////////////////////////////////////////////////////////////////////////////

  assign gnt_o         = gnt;
  assign rsp_vld_o     = (state_q == l1_pkg::BK_RSP);  // level until taken
  assign rsp_o.rdata    = rdata_q;
  assign rsp_o.tid      = req_q.tid;
  assign rsp_o.is_store = req_q.we;

  assign mem_req_vld_o  = (state_q == l1_pkg::BK_MISS_REQ) ||
                          (state_q == l1_pkg::BK_STORE_REQ);
  assign mem_req_o.op   = req_q.we ? l1_pkg::MEM_STORE : l1_pkg::MEM_LOAD;
  assign mem_req_o.addr = {req_q.addr[l1_pkg::ADDR_W-1:2], 2'b00};
  assign mem_req_o.data = req_q.wdata;
  assign mem_req_o.bank = '0;  // arbiter stamps the real index

  assign miss_o = miss_q;
  assign busy_o = (state_q != l1_pkg::BK_IDLE);

  // flush is only allowed when the whole cache is quiet
  a_flush_idle : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    flush_i |-> (state_q == l1_pkg::BK_IDLE)
  ) else $error("flush_i while bank busy");

  // the arbiter must only steer returns to a bank that waits for one
  a_rtrn_in_wait : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    mem_rtrn_vld_i |-> (state_q == l1_pkg::BK_MISS_WAIT)
  ) else $error("memory return outside BK_MISS_WAIT");

endmodule

// ==== src/req_router.sv ====
// cpu side request router
//   decodes the bank from the word address and forwards the request
//   returns the addressed bank's grant to the cpu
//   merges held bank responses by fixed priority into one response register

`timescale 1ns/100ps

module req_router #(
  parameter int NumBanks = 4
) (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  // cpu side
  input  logic                                 req_i,
  input  l1_pkg::cpu_req_t                     req_data_i,
  output logic                                 gnt_o,
  output logic                                 rsp_vld_o,
  output l1_pkg::cpu_rsp_t                     rsp_o,
  // bank side
  output logic             [NumBanks-1:0]      bank_req_o,
  output l1_pkg::cpu_req_t                     bank_req_data_o,
  input  logic             [NumBanks-1:0]      bank_gnt_i,
  input  logic             [NumBanks-1:0]      bank_rsp_vld_i,
  input  l1_pkg::cpu_rsp_t [NumBanks-1:0]      bank_rsp_i,
  output logic             [NumBanks-1:0]      bank_rsp_take_o
);

  localparam int BankW = $clog2(NumBanks);

  logic [BankW-1:0] bank_sel;   // addressed bank
  logic [BankW-1:0] take_idx;   // lowest valid responder
  logic             rsp_vld_q;
  l1_pkg::cpu_rsp_t rsp_q;

  ////////////////////////////////////////////////////////////////////////////
  // request path
  ////////////////////////////////////////////////////////////////////////////

  assign bank_sel        = req_data_i.addr[2 +: BankW];  // word-interleaved
  assign bank_req_data_o = req_data_i;                    // shared by all banks

  always_comb begin
    bank_req_o           = '0;
    bank_req_o[bank_sel] = req_i;  // one-hot towards the addressed bank
  end

  assign gnt_o = req_i & bank_gnt_i[bank_sel];  // bank grants when idle

  ////////////////////////////////////////////////////////////////////////////
  // response merge
  ////////////////////////////////////////////////////////////////////////////

  // fixed priority, lowest index wins
  always_comb begin
    take_idx = '0;
    for (int i = NumBanks - 1; i >= 0; i--) begin
      if (bank_rsp_vld_i[i]) take_idx = BankW'(i);
    end
  end

  always_comb begin
    bank_rsp_take_o = '0;
    bank_rsp_take_o[take_idx] = |bank_rsp_vld_i;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rsp_vld_q <= 1'b0;
    end else begin
      rsp_vld_q <= |bank_rsp_vld_i;  // one cycle from take to rsp_vld_o
    end
  end

  always_ff @(posedge clk_i) begin
    rsp_q <= bank_rsp_i[take_idx];  // payload only, qualified by rsp_vld_q
  end

  assign rsp_vld_o = rsp_vld_q;
  assign rsp_o     = rsp_q;

  // a taken response leaves its bank, so no response is taken twice
  a_single_take : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    |bank_rsp_take_o |=> ((bank_rsp_vld_i & $past(bank_rsp_take_o)) == '0)
  ) else $error("bank response still held after it was taken");

endmodule

// ==== src/l1_pkg.sv ====
// shared definitions for the banked write-through L1 data cache
//   widths for address, data, transaction id and bank tag
//   memory opcode and bank FSM state enums
//   packed request/response structs for the CPU and memory sides

package l1_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////////////////////

  localparam int ADDR_W    = 16;  // byte address
  localparam int DATA_W    = 32;  // one word per line
  localparam int TID_W     = 4;   // cpu transaction id
  localparam int BANK_ID_W = 3;   // up to 8 banks on the memory port

  ////////////////////////////////////////////////////////////////////////////
  // enums
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic {
    MEM_LOAD  = 1'b0,
    MEM_STORE = 1'b1
  } mem_op_e;

  typedef enum logic [2:0] {
    BK_IDLE,       // ready for a new cpu request
    BK_MISS_REQ,   // load miss, waiting for memory ack
    BK_MISS_WAIT,  // ack seen, waiting for return data
    BK_STORE_REQ,  // write-through, waiting for memory ack
    BK_RSP         // response held until the router takes it
  } bank_state_e;

  ////////////////////////////////////////////////////////////////////////////
  // structs
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic              we;     // 1 = store
    logic [ADDR_W-1:0] addr;   // byte address
    logic [DATA_W-1:0] wdata;
    logic [TID_W-1:0]  tid;
  } cpu_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] rdata;     // zero for stores
    logic [TID_W-1:0]  tid;       // echoed from the request
    logic              is_store;
  } cpu_rsp_t;

  typedef struct packed {
    mem_op_e              op;
    logic [ADDR_W-1:0]    addr;   // word aligned
    logic [DATA_W-1:0]    data;   // store data, don't care for loads
    logic [BANK_ID_W-1:0] bank;   // stamped by the arbiter
  } mem_req_t;

  typedef struct packed {
    logic [DATA_W-1:0]    data;
    logic [BANK_ID_W-1:0] bank;   // steers the return to its bank
  } mem_rtrn_t;

endpackage
